// ==== sources.f ====
logic/core_pkg.sv
logic/core_if.sv
logic/dispatch_unit.sv
logic/reservation_station.sv
logic/alu_unit.sv
logic/rob_pointers.sv
logic/reorder_buffer.sv
logic/register_file.sv
logic/ooo_core.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f sources.f -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/core_tb_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^No errors$"; then
    exit 0
fi
exit 1

// ==== test/core_tb.sv ====
module core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_independent = 12;
    localparam int num_chain = 12;
    localparam int num_burst = 24;
    localparam int num_random = 120;
    localparam int num_insts = num_independent + num_chain + num_burst + num_random;

    logic       clock;
    logic       reset;
    logic       inst_valid;
    inst_word_t inst;
    logic       inst_ready;
    logic       commit_valid;
    reg_idx_t   commit_idx;
    xlen_t      commit_data;

    // architectural state of the model, plus expected commits in order
    xlen_t    model_regs [32];
    reg_idx_t exp_idx [$];
    xlen_t    exp_data [$];
    logic     saw_stall;
    integer   seed;

    ooo_core #(.rob_depth(8), .rs_depth(4)) dut0 (
        .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .inst_ready(inst_ready), .commit_valid(commit_valid),
        .commit_idx(commit_idx), .commit_data(commit_data)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // failure handling and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_commit_idx(input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("Error at %0t: commit_idx got %0d expected %0d", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_commit_data(input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error at %0t: commit_data got %08h expected %08h", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////////////////////////
    function automatic inst_word_t make_r(input logic [6:0] f7, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3,
                                          input reg_idx_t rd);
        inst_word_t w;
        w.r_view.funct7 = f7;
        w.r_view.rs2 = rs2;
        w.r_view.rs1 = rs1;
        w.r_view.funct3 = f3;
        w.r_view.rd = rd;
        w.r_view.opcode = OPC_OP;
        return w;
    endfunction

    function automatic inst_word_t make_i(input logic [11:0] imm, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd);
        inst_word_t w;
        w.i_view.imm = imm;
        w.i_view.rs1 = rs1;
        w.i_view.funct3 = f3;
        w.i_view.rd = rd;
        w.i_view.opcode = OPC_OP_IMM;
        return w;
    endfunction

    // cycles through the four named funct3 values
    function automatic logic [2:0] funct3_of(input int k);
        case (k % 4)
            0: return F3_ADD;
            1: return F3_XOR;
            2: return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model, one instruction in program order
    ////////////////////////////////////////////////////////////
    function automatic void model_execute(input inst_word_t w);
        logic  is_imm;
        xlen_t a;
        xlen_t b;
        xlen_t res;
        is_imm = (w.r_view.opcode == OPC_OP_IMM);
        a = model_regs[w.r_view.rs1];
        // op-imm takes the sign extended immediate
        b = is_imm ? {{20{w.i_view.imm[11]}}, w.i_view.imm} : model_regs[w.r_view.rs2];
        case (w.r_view.funct3)
            F3_XOR: res = a ^ b;
            F3_OR: res = a | b;
            F3_AND: res = a & b;
            F3_ADD: res = (!is_imm && w.r_view.funct7 == F7_SUB) ? a - b : a + b;
            // unlisted funct3 falls back to add
            default: res = a + b;
        endcase
        exp_idx.push_back(w.r_view.rd);
        exp_data.push_back(res);
        // x0 commits its value but keeps reading zero
        if (w.r_view.rd != '0) begin
            model_regs[w.r_view.rd] = res;
        end
    endfunction

    // hold the word until an edge with ready high
    task automatic send(input inst_word_t w);
        logic accepted;
        inst <= w;
        inst_valid <= 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            accepted = inst_ready;
            if (!inst_ready) begin
                saw_stall = 1'b1;
            end
            @(posedge clock);
        end
        model_execute(w);
    endtask

    // compare every commit against the model queue
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (exp_idx.size() == 0) begin
                $display("A commit arrived with no instruction outstanding");
                stop_with_failure();
            end else begin
                check_commit_idx(commit_idx, exp_idx.pop_front());
                check_commit_data(commit_data, exp_data.pop_front());
            end
        end
    end

    // watchdog
    initial begin
        repeat (num_insts * 20 + 100) @(posedge clock);
        $display("Timeout: not every instruction committed in time");
        stop_with_failure();
    end

    initial begin
        reg_idx_t    rd;
        logic [31:0] r;
        logic [31:0] gap;
        seed = 32'h6719;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = '0;
        saw_stall = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // idle state after reset
        @(negedge clock);
        check_flag(commit_valid, 1'b0, "commit_valid");
        check_flag(inst_ready, 1'b1, "inst_ready");
        @(posedge clock);

        // independent op-imm from x0
        for (int i = 0; i < num_independent; i++) begin
            r = $random(seed);
            send(make_i(r[11:0], 5'd0, funct3_of(i), reg_idx_t'(i + 1)));
        end

        // raw chains over x5..x8, each reads the previous result
        for (int i = 0; i < num_chain; i++) begin
            send(make_r((i % 3 == 0) ? F7_SUB : 7'd0, reg_idx_t'(5 + (i + 2) % 4),
                        reg_idx_t'(5 + (i + 3) % 4), funct3_of(i), reg_idx_t'(5 + i % 4)));
        end

        ////////////////////////////////////////////////////////////
        // dependent burst, station fills up
        ////////////////////////////////////////////////////////////
        saw_stall = 1'b0;
        for (int i = 0; i < num_burst; i++) begin
            if (i % 2 == 0) begin
                send(make_i(12'd3, 5'd10, F3_ADD, 5'd10));
            end else begin
                send(make_r(7'd0, 5'd10, 5'd11, F3_ADD, 5'd11));
            end
        end
        if (!saw_stall) begin
            $display("inst_ready never dropped during the dependent burst");
            stop_with_failure();
        end

        // random r/i mix with idle gaps and x0 writes
        for (int i = 0; i < num_random; i++) begin
            r = $random(seed);
            gap = $random(seed);
            rd = r[4:0];
            if (r[31:29] == 3'b000) begin
                rd = '0;
            end
            if (r[18]) begin
                send(make_i(r[30:19], r[9:5], r[17:15], rd));
            end else begin
                send(make_r(r[28] ? F7_SUB : r[27:21], r[14:10], r[9:5], r[17:15], rd));
            end
            if (gap[1:0] == 2'b00) begin
                inst_valid <= 1'b0;
                @(posedge clock);
            end
        end
        inst_valid <= 1'b0;

        // drain, then the core should sit idle with room for more
        while (exp_idx.size() != 0) begin
            @(posedge clock);
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        if (inst_ready === 1'b1 && commit_valid === 1'b0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Core not idle after every instruction committed");
            stop_with_failure();
        end
    end

endmodule

// ==== logic/ooo_core.sv ====
module ooo_core import core_pkg::*; #(
    parameter int rob_depth = 8,
    parameter int rs_depth = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       inst_valid,
    input  inst_word_t inst,
    output logic       inst_ready,
    output logic       commit_valid,
    output reg_idx_t   commit_idx,
    output xlen_t      commit_data
);
    dispatch_if disp_bus ();
    cdb_if      cdb_bus ();

    logic     rs_full, rob_full, alloc;
    reg_idx_t alloc_dest;
    rob_tag_t alloc_tag, lookup_tag1, lookup_tag2;
    logic     lookup_ready1, lookup_ready2;
    xlen_t    lookup_value1, lookup_value2;
    reg_idx_t rf_addr1, rf_addr2;
    xlen_t    rf_data1, rf_data2;
    logic     retire_en;
    rob_tag_t retire_tag;
    reg_idx_t retire_idx;
    xlen_t    retire_data;

    // select path between station and alu
    logic     issue_valid;
    alu_op_t  issue_op;
    rob_tag_t issue_tag;
    xlen_t    issue_a, issue_b;

    dispatch_unit disp0 (
        .clock(clock), .reset(reset), .inst(inst), .inst_valid(inst_valid),
        .inst_ready(inst_ready), .rs_full(rs_full), .rob_full(rob_full),
        .alloc(alloc), .alloc_dest(alloc_dest), .alloc_tag(alloc_tag),
        .lookup_tag1(lookup_tag1), .lookup_tag2(lookup_tag2),
        .lookup_ready1(lookup_ready1), .lookup_ready2(lookup_ready2),
        .lookup_value1(lookup_value1), .lookup_value2(lookup_value2),
        .rf_addr1(rf_addr1), .rf_addr2(rf_addr2),
        .rf_data1(rf_data1), .rf_data2(rf_data2),
        .retire_en(retire_en), .retire_tag(retire_tag), .retire_idx(retire_idx),
        .cdb(cdb_bus), .disp(disp_bus)
    );

    reservation_station #(.rs_depth(rs_depth)) rs0 (
        .clock(clock), .reset(reset), .disp(disp_bus), .cdb(cdb_bus),
        .full(rs_full), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_tag(issue_tag), .issue_a(issue_a), .issue_b(issue_b)
    );

    alu_unit alu0 (
        .clock(clock), .reset(reset), .issue_valid(issue_valid),
        .issue_op(issue_op), .issue_tag(issue_tag),
        .issue_a(issue_a), .issue_b(issue_b), .cdb(cdb_bus)
    );

    reorder_buffer #(.rob_depth(rob_depth)) rob0 (
        .clock(clock), .reset(reset), .alloc(alloc), .alloc_dest(alloc_dest),
        .alloc_tag(alloc_tag), .rob_full(rob_full),
        .lookup_tag1(lookup_tag1), .lookup_tag2(lookup_tag2),
        .lookup_ready1(lookup_ready1), .lookup_ready2(lookup_ready2),
        .lookup_value1(lookup_value1), .lookup_value2(lookup_value2),
        .cdb(cdb_bus), .retire_en(retire_en), .retire_tag(retire_tag),
        .retire_idx(retire_idx), .retire_data(retire_data),
        .commit_valid(commit_valid), .commit_idx(commit_idx),
        .commit_data(commit_data)
    );

    register_file rf0 (
        .clock(clock), .reset(reset), .rf_addr1(rf_addr1), .rf_addr2(rf_addr2),
        .rf_data1(rf_data1), .rf_data2(rf_data2), .retire_en(retire_en),
        .retire_idx(retire_idx), .retire_data(retire_data)
    );

endmodule

// ==== logic/register_file.sv ====
module register_file import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t rf_addr1,
    input  reg_idx_t rf_addr2,
    output xlen_t    rf_data1,
    output xlen_t    rf_data2,
    input  logic     retire_en,
    input  reg_idx_t retire_idx,
    input  xlen_t    retire_data
);
    xlen_t regs [32];

    assign rf_data1 = regs[rf_addr1];
    assign rf_data2 = regs[rf_addr2];

    // x0 is never written, so it reads zero after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_en && retire_idx != '0) begin
            regs[retire_idx] <= retire_data;
        end
    end

endmodule

// ==== logic/reorder_buffer.sv ====
module reorder_buffer import core_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     alloc,
    input  reg_idx_t alloc_dest,
    output rob_tag_t alloc_tag,
    output logic     rob_full,
    input  rob_tag_t lookup_tag1,
    input  rob_tag_t lookup_tag2,
    output logic     lookup_ready1,
    output logic     lookup_ready2,
    output xlen_t    lookup_value1,
    output xlen_t    lookup_value2,
    cdb_if.receiver  cdb,
    output logic     retire_en,
    output rob_tag_t retire_tag,
    output reg_idx_t retire_idx,
    output xlen_t    retire_data,
    output logic     commit_valid,
    output reg_idx_t commit_idx,
    output xlen_t    commit_data
);
    localparam int IW = $clog2(rob_depth);

    reg_idx_t             dest_q [rob_depth];
    xlen_t                value_q [rob_depth];
    logic [rob_depth-1:0] done;
    rob_tag_t             head;
    rob_tag_t             tail;

    rob_pointers #(.rob_depth(rob_depth)) ptr0 (
        .clock     (clock),
        .reset     (reset),
        .alloc     (alloc),
        .retire_en (retire_en),
        .head      (head),
        .tail      (tail),
        .full      (rob_full)
    );

    assign alloc_tag = tail;

    // operand lookup for dispatch
    assign lookup_ready1 = done[lookup_tag1[IW-1:0]];
    assign lookup_ready2 = done[lookup_tag2[IW-1:0]];
    assign lookup_value1 = value_q[lookup_tag1[IW-1:0]];
    assign lookup_value2 = value_q[lookup_tag2[IW-1:0]];

    // in-order retire from the head
    assign retire_en = done[head[IW-1:0]];
    assign retire_tag = head;
    assign retire_idx = dest_q[head[IW-1:0]];
    assign retire_data = value_q[head[IW-1:0]];

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (retire_en) begin
                done[head[IW-1:0]] <= 1'b0;
            end
            if (alloc) begin
                done[tail[IW-1:0]] <= 1'b0;
            end
            if (cdb.valid) begin
                done[cdb.tag[IW-1:0]] <= 1'b1;
            end
            commit_valid <= retire_en;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            dest_q[tail[IW-1:0]] <= alloc_dest;
        end
        if (cdb.valid) begin
            value_q[cdb.tag[IW-1:0]] <= cdb.value;
        end
        if (retire_en) begin
            commit_idx <= retire_idx;
            commit_data <= retire_data;
        end
    end

    // a done head implies the pointers see an occupied buffer
    a_no_retire_empty: assert property (@(posedge clock) disable iff (reset)
        retire_en |-> (head != tail || rob_full));

endmodule

// ==== logic/rob_pointers.sv ====
module rob_pointers import core_pkg::*; #(
    parameter int rob_depth = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     alloc,
    input  logic     retire_en,
    output rob_tag_t head,
    output rob_tag_t tail,
    output logic     full
);
    // occupancy, one bit wider than an index
    logic [$clog2(rob_depth):0] count;

    assign full = (count == rob_depth);

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= (tail == rob_tag_t'(rob_depth - 1)) ? '0 : tail + 1'b1;
            end
            if (retire_en) begin
                head <= (head == rob_tag_t'(rob_depth - 1)) ? '0 : head + 1'b1;
            end
            case ({alloc, retire_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_in_range: assert property (@(posedge clock) disable iff (reset)
        count <= rob_depth);

endmodule

// ==== logic/alu_unit.sv ====
module alu_unit import core_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     issue_valid,
    input  alu_op_t  issue_op,
    input  rob_tag_t issue_tag,
    input  xlen_t    issue_a,
    input  xlen_t    issue_b,
    cdb_if.driver    cdb
);
    xlen_t result;

    always_comb begin
        case (issue_op)
            ALU_SUB: result = issue_a - issue_b;
            ALU_XOR: result = issue_a ^ issue_b;
            ALU_OR: result = issue_a | issue_b;
            ALU_AND: result = issue_a & issue_b;
            default: result = issue_a + issue_b;
        endcase
    end

    // result goes on the bus one cycle after select
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            cdb.tag <= issue_tag;
            cdb.value <= result;
        end
    end

endmodule

// ==== logic/reservation_station.sv ====
module reservation_station import core_pkg::*; #(
    parameter int rs_depth = 4
) (
    input  logic         clock,
    input  logic         reset,
    dispatch_if.receiver disp,
    cdb_if.receiver      cdb,
    output logic         full,
    output logic         issue_valid,
    output alu_op_t      issue_op,
    output rob_tag_t     issue_tag,
    output xlen_t        issue_a,
    output xlen_t        issue_b
);
    localparam int IW = (rs_depth > 1) ? $clog2(rs_depth) : 1;

    logic [rs_depth-1:0] valid;
    // age counts the younger entries still waiting
    logic [IW-1:0]       age [rs_depth];
    alu_op_t             op_q [rs_depth];
    rob_tag_t            dest_q [rs_depth];
    logic [rs_depth-1:0] rdy1;
    logic [rs_depth-1:0] rdy2;
    rob_tag_t            tag1 [rs_depth];
    rob_tag_t            tag2 [rs_depth];
    xlen_t               val1 [rs_depth];
    xlen_t               val2 [rs_depth];

    logic [IW-1:0] sel_idx;
    logic [IW-1:0] free_idx;

    assign full = &valid;

    // oldest ready entry, plus the lowest free slot
    always_comb begin
        issue_valid = 1'b0;
        sel_idx = '0;
        free_idx = '0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IW'(i);
            end
        end
        for (int i = 0; i < rs_depth; i++) begin
            if (valid[i] && rdy1[i] && rdy2[i] &&
                (!issue_valid || age[i] > age[sel_idx])) begin
                issue_valid = 1'b1;
                sel_idx = IW'(i);
            end
        end
    end

    assign issue_op = op_q[sel_idx];
    assign issue_tag = dest_q[sel_idx];
    assign issue_a = val1[sel_idx];
    assign issue_b = val2[sel_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[sel_idx] <= 1'b0;
            end
            if (disp.load) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // entry payload, ages and wakeup
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            if (valid[i]) begin
                // one more younger on load, one fewer when a younger one leaves
                age[i] <= age[i] + IW'(disp.load)
                          - IW'(issue_valid && age[i] > age[sel_idx]);
            end
            // catch broadcast results
            if (valid[i] && cdb.valid && !rdy1[i] && tag1[i] == cdb.tag) begin
                rdy1[i] <= 1'b1;
                val1[i] <= cdb.value;
            end
            if (valid[i] && cdb.valid && !rdy2[i] && tag2[i] == cdb.tag) begin
                rdy2[i] <= 1'b1;
                val2[i] <= cdb.value;
            end
        end
        if (disp.load) begin
            age[free_idx] <= '0;
            op_q[free_idx] <= disp.op;
            dest_q[free_idx] <= disp.dest;
            rdy1[free_idx] <= disp.src1_ready;
            tag1[free_idx] <= disp.src1_tag;
            val1[free_idx] <= disp.src1_value;
            rdy2[free_idx] <= disp.src2_ready;
            tag2[free_idx] <= disp.src2_tag;
            val2[free_idx] <= disp.src2_value;
        end
    end

    a_no_load_when_full: assert property (@(posedge clock) disable iff (reset)
        full |-> !disp.load);

endmodule

// ==== logic/dispatch_unit.sv ====
module dispatch_unit import core_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  inst_word_t inst,
    input  logic       inst_valid,
    output logic       inst_ready,
    input  logic       rs_full,
    input  logic       rob_full,
    output logic       alloc,
    output reg_idx_t   alloc_dest,
    input  rob_tag_t   alloc_tag,
    output rob_tag_t   lookup_tag1,
    output rob_tag_t   lookup_tag2,
    input  logic       lookup_ready1,
    input  logic       lookup_ready2,
    input  xlen_t      lookup_value1,
    input  xlen_t      lookup_value2,
    output reg_idx_t   rf_addr1,
    output reg_idx_t   rf_addr2,
    input  xlen_t      rf_data1,
    input  xlen_t      rf_data2,
    input  logic       retire_en,
    input  rob_tag_t   retire_tag,
    input  reg_idx_t   retire_idx,
    cdb_if.receiver    cdb,
    dispatch_if.driver disp
);
    // map table, one busy bit and producer tag per register
    logic [31:0] map_busy;
    rob_tag_t    map_tag [32];

    logic     is_imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    imm;

    assign is_imm = (inst.r_view.opcode == OPC_OP_IMM);
    assign rs1 = inst.r_view.rs1;
    assign rs2 = inst.r_view.rs2;
    assign rd = inst.r_view.rd;
    assign imm = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};

    // stall on either queue being full
    assign inst_ready = !rs_full && !rob_full;
    assign alloc = inst_valid && inst_ready;
    assign alloc_dest = rd;

    assign rf_addr1 = rs1;
    assign rf_addr2 = rs2;
    assign lookup_tag1 = map_tag[rs1];
    assign lookup_tag2 = map_tag[rs2];

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (inst.r_view.funct3)
            F3_XOR: disp.op = ALU_XOR;
            F3_OR: disp.op = ALU_OR;
            F3_AND: disp.op = ALU_AND;
            F3_ADD: begin
                // sub only exists in the register form
                if (!is_imm && inst.r_view.funct7 == F7_SUB) begin
                    disp.op = ALU_SUB;
                end else begin
                    disp.op = ALU_ADD;
                end
            end
            default: disp.op = ALU_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // operand rename
    ////////////////////////////////////////////////////////////
    always_comb begin
        disp.load = alloc;
        disp.dest = alloc_tag;

        // source 1: regfile, finished rob entry, cdb, else wait
        disp.src1_tag = map_tag[rs1];
        disp.src1_ready = 1'b1;
        disp.src1_value = rf_data1;
        if (rs1 != '0 && map_busy[rs1]) begin
            if (lookup_ready1) begin
                disp.src1_value = lookup_value1;
            end else if (cdb.valid && cdb.tag == map_tag[rs1]) begin
                disp.src1_value = cdb.value;
            end else begin
                disp.src1_ready = 1'b0;
            end
        end

        // source 2, the immediate for op-imm
        disp.src2_tag = map_tag[rs2];
        disp.src2_ready = 1'b1;
        disp.src2_value = rf_data2;
        if (is_imm) begin
            disp.src2_value = imm;
        end else if (rs2 != '0 && map_busy[rs2]) begin
            if (lookup_ready2) begin
                disp.src2_value = lookup_value2;
            end else if (cdb.valid && cdb.tag == map_tag[rs2]) begin
                disp.src2_value = cdb.value;
            end else begin
                disp.src2_ready = 1'b0;
            end
        end
    end

    // busy bits
    always_ff @(posedge clock) begin
        if (reset) begin
            map_busy <= '0;
        end else begin
            // only the newest producer frees its register
            if (retire_en && map_tag[retire_idx] == retire_tag) begin
                map_busy[retire_idx] <= 1'b0;
            end
            // a new rename wins over a retire in the same cycle
            if (alloc && rd != '0) begin
                map_busy[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc && rd != '0) begin
            map_tag[rd] <= alloc_tag;
        end
    end

    // a waiting source names an older producer still in flight, never the new tag
    a_wait_tag_in_flight: assert property (@(posedge clock) disable iff (reset)
        alloc |-> (disp.src1_ready || disp.src1_tag != alloc_tag) &&
                  (disp.src2_ready || disp.src2_tag != alloc_tag));

endmodule

// ==== logic/core_if.sv ====
// one renamed instruction on its way into the station
interface dispatch_if import core_pkg::*; ();
    logic     load;
    alu_op_t  op;
    rob_tag_t dest;
    logic     src1_ready;
    xlen_t    src1_value;
    rob_tag_t src1_tag;
    logic     src2_ready;
    xlen_t    src2_value;
    rob_tag_t src2_tag;

    modport driver (output load, op, dest, src1_ready, src1_value, src1_tag,
                    src2_ready, src2_value, src2_tag);
    modport receiver (input load, op, dest, src1_ready, src1_value, src1_tag,
                      src2_ready, src2_value, src2_tag);
endinterface

// result broadcast, valid is a single cycle pulse
interface cdb_if import core_pkg::*; ();
    logic     valid;
    rob_tag_t tag;
    xlen_t    value;

    modport driver (output valid, tag, value);
    modport receiver (input valid, tag, value);
endinterface

// ==== logic/core_pkg.sv ====
package core_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    localparam int XLEN = 32;
    // rob tags are sized for the deepest rob
    localparam int MAX_ROB_DEPTH = 16;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [$clog2(MAX_ROB_DEPTH)-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // rv32i encodings
    ////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    // two readings of one instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_view;
    } inst_word_t;

endpackage
